//--- tb.f
mem_ctrl_pkg.sv
mem_arbiter.sv
bus_steer.sv
memory_controller.sv
tb_mem_model.sv
tb_memory_controller.sv

//--- tb_memory_controller.sv
// testbench for the memory controller with fetch and data traffic against a shadow memory
module tb_memory_controller
    import mem_ctrl_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // 150 accesses at up to 10 cycles each plus reset
    localparam int unsigned TIMEOUT_CYCLES = 2500;

    logic        CLK;
    logic        rst_n;
    bus_req_t    i_req;
    bus_rsp_t    i_rsp;
    bus_req_t    d_req;
    bus_rsp_t    d_rsp;
    bus_req_t    mem_req;
    bus_rsp_t    mem_rsp;
    logic [31:0] access_count;

    // expected memory contents in memory lane order
    logic [31:0] shadow [0:255];
    logic [31:0] rng_state = 32'd85;
    int unsigned cycle_cnt = 0;

    // arbiter FSM state for waves and the flush check
    arb_state_t  arb_state;
    assign arb_state = dut_i.arbiter_i.state;

    memory_controller #(
        .BUS_LITTLE_ENDIAN (1'b1)
    ) dut_i (
        .CLK     (CLK),
        .rst_n   (rst_n),
        .i_req   (i_req),
        .i_rsp   (i_rsp),
        .d_req   (d_req),
        .d_rsp   (d_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    tb_mem_model mem_i (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .access_count (access_count)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    function logic [31:0] random_word();
        rng_state = lcg_next(rng_state);
        return rng_state;
    endfunction

    // 16 test words spread over the array
    function automatic logic [7:0] word_index(input logic [3:0] k);
        return {k, ~k};
    endfunction

    // new memory word after a core store
    // core byte i lands in memory lane 3-i
    function automatic logic [31:0] ref_mem_word(input logic [31:0] old_word,
                                                 input logic [31:0] wdata,
                                                 input logic [3:0] be);
        logic [31:0] w;
        w = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                w[8*(3-i) +: 8] = wdata[8*i +: 8];
            end
        end
        return w;
    endfunction

    // word as the core sees it on a load
    function automatic logic [31:0] core_view(input logic [31:0] mem_word);
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = mem_word[8*(3-i) +: 8];
        end
        return w;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s got %h expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // run timer
    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("the run timed out after %0d cycles", cycle_cnt);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // completed accesses against the shadow
    always @(posedge CLK) begin : compare
        logic [7:0] d_idx;
        logic [7:0] i_idx;
        d_idx = d_req.addr[9:2];
        i_idx = i_req.addr[9:2];
        if (rst_n && (d_req.ren || d_req.wen) && !d_rsp.busy) begin
            if (d_req.wen) begin
                shadow[d_idx] = ref_mem_word(shadow[d_idx], d_req.wdata, d_req.byte_en);
            end else begin
                check_value(d_rsp.rdata, core_view(shadow[d_idx]), "data read");
                check_value(mem_i.mem[d_idx], shadow[d_idx], "memory word");
            end
        end
        if (rst_n && i_req.ren && !i_rsp.busy) begin
            check_value(i_rsp.rdata, core_view(shadow[i_idx]), "fetch read");
        end
    end

    task automatic data_access(input logic we, input logic [7:0] idx,
                               input logic [31:0] wdata, input logic [3:0] be,
                               output int unsigned done_cycle);
        @(negedge CLK);
        d_req <= '{ren: !we, wen: we, addr: {22'd0, idx, 2'd0}, wdata: wdata, byte_en: be};
        do begin
            @(posedge CLK);
        end while (d_rsp.busy);
        done_cycle = cycle_cnt;
        @(negedge CLK);
        d_req <= '0;
    endtask

    task automatic fetch(input logic [7:0] idx, output int unsigned done_cycle);
        @(negedge CLK);
        i_req <= '{ren: 1'b1, wen: 1'b0, addr: {22'd0, idx, 2'd0}, wdata: '0, byte_en: 4'hf};
        do begin
            @(posedge CLK);
        end while (i_rsp.busy);
        done_cycle = cycle_cnt;
        @(negedge CLK);
        i_req <= '0;
    endtask

    // ren held for a single cycle as on a flush
    task automatic abort_fetch(input logic [7:0] idx);
        @(negedge CLK);
        i_req <= '{ren: 1'b1, wen: 1'b0, addr: {22'd0, idx, 2'd0}, wdata: '0, byte_en: 4'hf};
        @(negedge CLK);
        i_req <= '0;
        // dropped fetch sends the FSM back to idle
        @(negedge CLK);
        check_value(arb_state, idle, "state after flush");
    endtask

    initial begin : stimulus
        int unsigned done_d;
        int unsigned done_i;
        logic [31:0] count_before;
        logic [31:0] rnd;
        logic [31:0] wdata;
        logic [7:0]  d_idx;
        logic [7:0]  i_idx;
        i_req = '0;
        d_req = '0;
        rst_n = 1'b0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        // both ports busy and the bus quiet before any request
        repeat (4) begin
            @(posedge CLK);
            check_value(i_rsp.busy, 1'b1, "fetch busy after reset");
            check_value(d_rsp.busy, 1'b1, "data busy after reset");
            check_value(mem_req.ren | mem_req.wen, 1'b0, "bus idle after reset");
        end
        // full-word stores give every test word a known value
        for (int k = 0; k < 16; k++) begin
            data_access(1'b1, word_index(k[3:0]), random_word(), 4'hf, done_d);
        end
        // partial stores then loads
        repeat (40) begin
            rnd   = random_word();
            wdata = random_word();
            data_access(1'b1, word_index(rnd[27:24]), wdata, rnd[19:16], done_d);
        end
        repeat (30) begin
            rnd = random_word();
            data_access(1'b0, word_index(rnd[27:24]), '0, 4'hf, done_d);
        end
        repeat (20) begin
            rnd = random_word();
            fetch(word_index(rnd[27:24]), done_i);
        end
        // both ports at once
        // data must finish first
        repeat (10) begin
            rnd   = random_word();
            wdata = random_word();
            d_idx = word_index(rnd[27:24]);
            i_idx = word_index(rnd[23:20]);
            fork
                data_access(rnd[31], d_idx, wdata, rnd[19:16], done_d);
                fetch(i_idx, done_i);
            join
            check_value(done_d < done_i, 1'b1, "data port finishes first");
        end
        // flushed fetch never reaches memory
        repeat (5) begin
            rnd          = random_word();
            count_before = access_count;
            abort_fetch(word_index(rnd[27:24]));
            data_access(1'b0, word_index(rnd[23:20]), '0, 4'hf, done_d);
            check_value(access_count, count_before + 32'd1, "access count after abort");
        end
        $display("Test passed");
        $finish;
    end

endmodule

//--- tb_mem_model.sv
// behavioural memory for the pipelined bus with random wait states and an access counter
module tb_mem_model
    import mem_ctrl_pkg::*;
(
    input  logic        CLK,
    input  logic        rst_n,
    input  bus_req_t    mem_req,
    output bus_rsp_t    mem_rsp,
    output logic [31:0] access_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // 256 words, indexed by addr[9:2]
    logic [31:0] mem [0:255];

    // data phase in flight
    logic        pending;
    logic        p_wen;
    logic [7:0]  p_index;
    // busy cycles left in this data phase
    logic [1:0]  wait_cnt;

    // wait state generator
    logic [31:0] lcg_state;
    logic [31:0] lcg_draw;

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    assign lcg_draw = lcg_next(lcg_state);

    // busy only while a data phase is being stretched
    assign mem_rsp = '{rdata: mem[p_index], busy: pending && (wait_cnt != 2'd0)};

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            pending      <= 1'b0;
            p_wen        <= 1'b0;
            p_index      <= '0;
            wait_cnt     <= '0;
            lcg_state    <= 32'd85;
            access_count <= '0;
            // fill pattern built from the whole word index
            for (int i = 0; i < 256; i++) begin
                mem[i] <= {i[7:0] ^ 8'ha5, ~i[7:0], i[7:0], i[7:0] + 8'h3c};
            end
        end else if (pending && (wait_cnt != 2'd0)) begin
            // hold the phase
            wait_cnt <= wait_cnt - 2'd1;
        end else begin
            // store lands its enabled lanes exactly as presented
            if (pending && p_wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_req.byte_en[b]) begin
                        mem[p_index][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                    end
                end
            end
            // new address phase accepted on this edge
            if (mem_req.ren || mem_req.wen) begin
                pending      <= 1'b1;
                p_wen        <= mem_req.wen;
                p_index      <= mem_req.addr[9:2];
                lcg_state    <= lcg_draw;
                wait_cnt     <= lcg_draw[17:16];
                access_count <= access_count + 32'd1;
            end else begin
                pending <= 1'b0;
            end
        end
    end

endmodule

//--- memory_controller.sv
// memory controller top joining the fetch and data ports onto one pipelined memory bus
module memory_controller
    import mem_ctrl_pkg::*;
#(
    // byte-reverse store data, load data and enables
    parameter bit BUS_LITTLE_ENDIAN = 1'b1
) (
    input  logic     CLK,
    input  logic     rst_n,
    // instruction fetch port
    input  bus_req_t i_req,
    output bus_rsp_t i_rsp,
    // data port
    input  bus_req_t d_req,
    output bus_rsp_t d_rsp,
    // external memory bus
    output bus_req_t mem_req,
    input  bus_rsp_t mem_rsp
);

    // address phase owner from the FSM
    req_src_t    src;

    // per-port completion
    logic        i_busy;
    logic        d_busy;

    // load data after the lane swap, shared by both ports
    logic [31:0] rdata;

    mem_arbiter arbiter_i (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .i_req    (i_req),
        .d_req    (d_req),
        .mem_busy (mem_rsp.busy),
        .src      (src),
        .i_busy   (i_busy),
        .d_busy   (d_busy)
    );

    bus_steer #(
        .BUS_LITTLE_ENDIAN (BUS_LITTLE_ENDIAN)
    ) steer_i (
        .src     (src),
        .i_req   (i_req),
        .d_req   (d_req),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .rdata   (rdata)
    );

    // a port only samples rdata when its own busy is low
    assign i_rsp = '{rdata: rdata, busy: i_busy};
    assign d_rsp = '{rdata: rdata, busy: d_busy};

endmodule

//--- bus_steer.sv
// request mux and byte-lane swap between the core ports and the memory bus
module bus_steer
    import mem_ctrl_pkg::*;
#(
    parameter bit BUS_LITTLE_ENDIAN = 1'b1
) (
    input  req_src_t    src,
    input  bus_req_t    i_req,
    input  bus_req_t    d_req,
    output bus_req_t    mem_req,
    input  bus_rsp_t    mem_rsp,
    output logic [31:0] rdata
);

    // request owning the address phase
    bus_req_t    sel_req;

    // store side after the lane swap
    logic [31:0] mem_wdata;
    logic [3:0]  mem_byte_en;

    // reverse the four bytes of a word
    function automatic logic [31:0] swap_bytes(input logic [31:0] word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    // reverse byte enables to follow the swapped lanes
    function automatic logic [3:0] swap_lanes(input logic [3:0] lanes);
        return {lanes[0], lanes[1], lanes[2], lanes[3]};
    endfunction

    // pick the address phase owner
    always_comb begin
        case (src)
            src_instr: sel_req = i_req;
            src_data:  sel_req = d_req;
            default:   sel_req = '0;
        endcase
    end

    // lane order between core and memory
    generate
        if (BUS_LITTLE_ENDIAN) begin : g_little
            assign mem_wdata   = swap_bytes(d_req.wdata);
            assign mem_byte_en = swap_lanes(d_req.byte_en);
            assign rdata       = swap_bytes(mem_rsp.rdata);
        end else begin : g_big
            assign mem_wdata   = d_req.wdata;
            assign mem_byte_en = d_req.byte_en;
            assign rdata       = mem_rsp.rdata;
        end
    endgenerate

    // build the memory request
    always_comb begin
        // idle phase leaves ren, wen and addr at zero
        mem_req.ren  = sel_req.ren;
        mem_req.wen  = sel_req.wen;
        mem_req.addr = sel_req.addr;
        // only the data port stores
        // it holds wdata and byte_en through both phases of its write
        // so the data phase stays correct while a fetch address overlaps it
        mem_req.wdata   = mem_wdata;
        mem_req.byte_en = mem_byte_en;
    end

endmodule

//--- mem_arbiter.sv
// instruction/data arbiter FSM with overlapped address and data phases and data priority
module mem_arbiter
    import mem_ctrl_pkg::*;
(
    input  logic     CLK,
    input  logic     rst_n,
    input  bus_req_t i_req,
    input  bus_req_t d_req,
    input  logic     mem_busy,
    output req_src_t src,
    output logic     i_busy,
    output logic     d_busy
);

    arb_state_t state;
    arb_state_t state_nxt;

    // request levels from each port
    logic i_active;
    logic d_active;

    // instruction port only ever reads
    assign i_active = i_req.ren;
    assign d_active = d_req.ren | d_req.wen;

    // state register
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                // data wins a tie
                if (d_active) begin
                    state_nxt = data_req;
                end else if (i_active) begin
                    state_nxt = instr_req;
                end
            end

            instr_req: begin
                // ren gone means a flush, the fetch is dropped
                if (!i_active) begin
                    state_nxt = idle;
                end else if (d_active) begin
                    state_nxt = instr_data_req;
                end else begin
                    state_nxt = instr_wait;
                end
            end

            instr_data_req: begin
                // fetch data phase ends, data address taken on the same edge
                if (!mem_busy) begin
                    state_nxt = data_wait;
                end
            end

            instr_wait: begin
                if (!mem_busy) begin
                    if (d_active) begin
                        state_nxt = data_req;
                    end else begin
                        state_nxt = idle;
                    end
                end else if (d_active) begin
                    // push the data address into the fetch data phase
                    state_nxt = instr_data_req;
                end
            end

            data_req: begin
                if (i_active) begin
                    state_nxt = data_instr_req;
                end else begin
                    state_nxt = data_wait;
                end
            end

            data_instr_req: begin
                // the data phase must finish before a flush can drop the fetch
                if (!mem_busy) begin
                    if (i_active) begin
                        state_nxt = instr_wait;
                    end else begin
                        state_nxt = idle;
                    end
                end
            end

            data_wait: begin
                if (!mem_busy) begin
                    if (i_active) begin
                        state_nxt = instr_req;
                    end else begin
                        state_nxt = idle;
                    end
                end else if (i_active) begin
                    state_nxt = data_instr_req;
                end
            end

            default: begin
                state_nxt = idle;
            end
        endcase
    end

    // outputs per state
    always_comb begin
        src    = src_none;
        i_busy = 1'b1;
        d_busy = 1'b1;
        case (state)
            instr_req: begin
                // a dropped ren issues nothing
                src = i_active ? src_instr : src_none;
            end

            instr_data_req: begin
                // data address phase, fetch data phase
                src    = src_data;
                i_busy = mem_busy;
            end

            instr_wait: begin
                i_busy = mem_busy;
            end

            data_req: begin
                src = src_data;
            end

            data_instr_req: begin
                // fetch address phase, data data phase
                src    = i_active ? src_instr : src_none;
                d_busy = mem_busy;
            end

            data_wait: begin
                d_busy = mem_busy;
            end

            default: begin
                src = src_none;
            end
        endcase
    end

endmodule

//--- mem_ctrl_pkg.sv
// memory controller package with shared bus structs, arbiter states and phase-owner encoding
package mem_ctrl_pkg;

    // one request on a core port or on the memory bus
    // field order follows the generic bus
    typedef struct packed {
        // read enable, level held until busy low
        logic        ren;
        // write enable, same rules as ren
        logic        wen;
        // byte address, word aligned for this design
        logic [31:0] addr;
        // store data, only meaningful with wen
        logic [31:0] wdata;
        // one bit per byte lane
        logic [3:0]  byte_en;
    } bus_req_t;

    // response seen by a port
    typedef struct packed {
        // load data, valid on the edge busy is low
        logic [31:0] rdata;
        // high while the access is still pending
        logic        busy;
    } bus_rsp_t;

    // arbiter FSM states
    // *_req states carry an address phase on the bus
    // a two-name state overlaps one port's data phase with the other's address phase
    // *_wait states are a data phase with nothing new on the bus
    typedef enum logic [2:0] {
        idle,
        instr_req,
        instr_data_req,
        instr_wait,
        data_req,
        data_instr_req,
        data_wait
    } arb_state_t;

    // owner of the address phase in the current cycle
    // src_none means no address phase at all
    typedef enum logic [1:0] {
        src_none  = 2'd0,
        src_instr = 2'd1,
        src_data  = 2'd2
    } req_src_t;

endpackage
